// ==== src/game_link_pkg.sv ====
package game_link_pkg;

    // ########################################################################
    // message letters exchanged between the consoles
    // ########################################################################

    // opponent lost, so the receiver has won
    localparam logic [7:0] msg_lost  = 8'h4C;
    // player waiting in the lobby
    localparam logic [7:0] msg_ready = 8'h52;
    // player landed a hit
    localparam logic [7:0] msg_hit   = 8'h48;

    // ########################################################################
    // event bundles
    // ########################################################################

    // events raised by the local game, one-cycle pulses
    typedef struct packed {
        logic lost;
        logic ready;
        logic hit;
    } local_event_t;

    // events decoded from the opponent's messages, one-cycle pulses
    typedef struct packed {
        logic lost;
        logic ready;
        logic hit;
    } remote_event_t;

endpackage

// ==== src/uart_pkg.sv ====
package uart_pkg;

    // ########################################################################
    // 8N1 frame
    // ########################################################################

    localparam int data_bits = 8;
    localparam int bit_idx_w = $clog2(data_bits);

    // line levels
    localparam logic line_idle = 1'b1;
    localparam logic start_bit = 1'b0;
    localparam logic stop_bit  = 1'b1;

    // bit period in system clocks
    localparam logic [3:0] clks_per_bit = 4'd8;
    // receiver samples the start bit here
    localparam logic [3:0] half_bit     = clks_per_bit >> 1;

    // ########################################################################
    // transmit buffer
    // ########################################################################

    localparam int fifo_depth  = 4;
    localparam int fifo_addr_w = $clog2(fifo_depth);

endpackage

// ==== src/link_msg_encoder.sv ====
module link_msg_encoder
    import game_link_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         multiplayer,
    input  local_event_t local_events,
    output logic [7:0]   msg_byte,
    output logic         msg_valid
);

    logic       send;
    logic [7:0] letter;

    // nothing leaves the console in single-player mode
    assign send = multiplayer && (|local_events);

    // one message per cycle, hit wins over ready, ready over lost
    always_comb begin
        if (local_events.hit) begin
            letter = msg_hit;
        end else if (local_events.ready) begin
            letter = msg_ready;
        end else begin
            letter = msg_lost;
        end
    end

    // strobe into the FIFO
    always_ff @(posedge clk) begin
        if (rst) begin
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= send;
        end
    end

    // letter only matters while msg_valid is high
    always_ff @(posedge clk) begin
        if (send) begin
            msg_byte <= letter;
        end
    end

endmodule

// ==== src/link_tx_fifo.sv ====
module link_tx_fifo
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] wr_data,
    input  logic       wr_en,
    input  logic       rd_en,
    output logic [7:0] rd_data,
    output logic       empty
);

    logic [7:0]             mem [fifo_depth];
    logic [fifo_addr_w-1:0] wr_ptr;
    logic [fifo_addr_w-1:0] rd_ptr;
    logic [fifo_addr_w:0]   count;
    logic                   full;
    logic                   do_wr;
    logic                   do_rd;

    assign empty = (count == '0);
    assign full  = (count == (fifo_addr_w + 1)'(fifo_depth));

    // a read frees a slot in the same cycle, so write on full+read is fine
    assign do_rd = rd_en && !empty;
    assign do_wr = wr_en && (!full || do_rd);

    // head entry is visible without a read
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== src/uart_tx.sv ====
module uart_tx
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rd_data,
    input  logic       empty,
    output logic       rd_en,
    output logic       tx
);

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

    tx_state_t              state;
    logic [3:0]             bit_cnt;
    logic [bit_idx_w-1:0]   bit_idx;
    logic [data_bits-1:0]   shift_q;
    logic                   bit_done;

    assign bit_done = (bit_cnt == clks_per_bit - 4'd1);

    // fetch when idle, or right at the end of a stop bit for back-to-back frames
    assign rd_en = !empty && ((state == tx_idle) || (state == tx_stop && bit_done));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= tx_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            bit_cnt <= (state == tx_idle || bit_done) ? 4'd0 : bit_cnt + 4'd1;
            case (state)
                tx_idle: begin
                    if (rd_en) begin
                        state <= tx_start;
                    end
                end
                tx_start: begin
                    if (bit_done) begin
                        bit_idx <= '0;
                        state   <= tx_data;
                    end
                end
                tx_data: begin
                    if (bit_done) begin
                        if (bit_idx == bit_idx_w'(data_bits - 1)) begin
                            state <= tx_stop;
                        end
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                default: begin
                    if (bit_done) begin
                        state <= rd_en ? tx_start : tx_idle;
                    end
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (rd_en) begin
            shift_q <= rd_data;
        end else if (state == tx_data && bit_done) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_comb begin
        case (state)
            tx_start: tx = start_bit;
            tx_data:  tx = shift_q[0];
            tx_stop:  tx = stop_bit;
            default:  tx = line_idle;
        endcase
    end

endmodule

// ==== src/uart_rx.sv ====
module uart_rx
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t            state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_prev;
    logic [3:0]           bit_cnt;
    logic [bit_idx_w-1:0] bit_idx;
    logic [data_bits-1:0] shift_q;
    logic                 fall;

    // falling edge on the synchronized line
    assign fall = (rx_prev == line_idle) && (rx_sync == start_bit);

    // ########################################################################
    // synchronizer and frame FSM
    // ########################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta  <= line_idle;
            rx_sync  <= line_idle;
            rx_prev  <= line_idle;
            state    <= rx_idle;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= rx;
            rx_sync  <= rx_meta;
            rx_prev  <= rx_sync;
            rx_valid <= 1'b0;
            bit_cnt  <= bit_cnt + 4'd1;
            case (state)
                rx_idle: begin
                    bit_cnt <= '0;
                    if (fall) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    // glitch shorter than half a bit goes back to idle
                    if (bit_cnt == half_bit - 4'd1) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= (rx_sync == start_bit) ? rx_data : rx_idle;
                    end
                end
                rx_data: begin
                    if (bit_cnt == clks_per_bit - 4'd1) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == bit_idx_w'(data_bits - 1)) begin
                            state <= rx_stop;
                        end
                    end
                end
                default: begin
                    // mid stop bit, framing error drops the byte
                    if (bit_cnt == clks_per_bit - 4'd1) begin
                        rx_valid <= (rx_sync == stop_bit);
                        state    <= rx_idle;
                    end
                end
            endcase
        end
    end

    // sampled at mid bit, lsb arrives first
    always_ff @(posedge clk) begin
        if (state == rx_data && bit_cnt == clks_per_bit - 4'd1) begin
            shift_q <= {rx_sync, shift_q[data_bits-1:1]};
        end
    end

    assign rx_byte = shift_q;

endmodule

// ==== src/link_msg_decoder.sv ====
module link_msg_decoder
    import game_link_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic [7:0]    rx_byte,
    input  logic          rx_valid,
    output remote_event_t remote_events,
    output logic [7:0]    last_char
);

    remote_event_t hit_on;

    // letter compare, unknown bytes match nothing
    always_comb begin
        hit_on.lost  = (rx_byte == msg_lost);
        hit_on.ready = (rx_byte == msg_ready);
        hit_on.hit   = (rx_byte == msg_hit);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            remote_events <= '0;
            last_char     <= 8'h00;
        end else begin
            // pulses last a single cycle
            remote_events <= '0;
            if (rx_valid) begin
                remote_events <= hit_on;
                last_char     <= rx_byte;
            end
        end
    end

endmodule

// ==== src/game_link.sv ====
module game_link
    import game_link_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          multiplayer,
    input  local_event_t  local_events,
    input  logic          rx,
    output logic          tx,
    output remote_event_t remote_events,
    output logic [7:0]    last_char
);

    logic [7:0] msg_byte;
    logic       msg_valid;
    logic [7:0] rd_data;
    logic       empty;
    logic       rd_en;
    logic [7:0] rx_byte;
    logic       rx_valid;

    // ########################################################################
    // transmit path
    // ########################################################################

    link_msg_encoder u_encoder (
        .clk          (clk),
        .rst          (rst),
        .multiplayer  (multiplayer),
        .local_events (local_events),
        .msg_byte     (msg_byte),
        .msg_valid    (msg_valid)
    );

    link_tx_fifo u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_data (msg_byte),
        .wr_en   (msg_valid),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .empty   (empty)
    );

    uart_tx u_tx (
        .clk     (clk),
        .rst     (rst),
        .rd_data (rd_data),
        .empty   (empty),
        .rd_en   (rd_en),
        .tx      (tx)
    );

    // ########################################################################
    // receive path
    // ########################################################################

    uart_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    link_msg_decoder u_decoder (
        .clk           (clk),
        .rst           (rst),
        .rx_byte       (rx_byte),
        .rx_valid      (rx_valid),
        .remote_events (remote_events),
        .last_char     (last_char)
    );

endmodule

// ==== sim/clock_gen.sv ====
module clock_gen #(
    parameter int period = 4
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

// ==== sim/game_link_tb.sv ====
module game_link_tb
    import game_link_pkg::*, uart_pkg::*;
();

    localparam int frame_cycles = 10 * int'(clks_per_bit);
    localparam int random_msgs  = 200;
    // singles, priority combos, burst, random run
    localparam int total_msgs   = 3 + 4 + 6 + random_msgs;
    // reset, idle checks, single-player run, settle windows and random gaps
    localparam int idle_cycles  = 250 + 10 * frame_cycles + random_msgs * 66;
    localparam int cycle_limit  = (total_msgs * frame_cycles + idle_cycles) * 3 / 2;

    logic          clk;
    logic          rst;
    logic          multiplayer;
    local_event_t  local_events;
    logic          link_up;
    logic          rx;
    logic          tx;
    remote_event_t remote_events;
    logic [7:0]    last_char;

    logic [31:0]   rng;
    int            cycle = 0;
    int            checks = 0;
    int            errors = 0;
    int            decoded = 0;
    int            tests_run = 0;
    int            tests_failed = 0;

    // encoder stage, FIFO contents and transmitter occupancy
    logic          enc_valid;
    logic [7:0]    enc_byte;
    int            frame_left;
    logic [7:0]    model_fifo [$];
    logic [7:0]    in_flight [$];

    clock_gen #(.period(4)) u_clk (.clk(clk));

    // tx looped back to rx once the DUT is out of reset
    assign rx = link_up ? tx : 1'b1;

    game_link UUT (
        .clk           (clk),
        .rst           (rst),
        .multiplayer   (multiplayer),
        .local_events  (local_events),
        .rx            (rx),
        .tx            (tx),
        .remote_events (remote_events),
        .last_char     (last_char)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic compare(input string name, input logic [7:0] got, input logic [7:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail %s: got 0x%02h, expected 0x%02h (cycle %0d)", name, got, want, cycle);
        end
    endtask

    // events stay on the inputs until the next call
    task automatic apply_events(input logic mp, input logic [2:0] ev);
        @(negedge clk);
        multiplayer  = mp;
        local_events = local_event_t'(ev);
    endtask

    task automatic wait_drain();
        apply_events(multiplayer, 3'b000);
        while (enc_valid || model_fifo.size() > 0 || frame_left > 0 || in_flight.size() > 0) begin
            @(negedge clk);
        end
        // a stray frame would surface within one frame time
        repeat (frame_cycles) @(negedge clk);
    endtask

    task automatic report_test(input string name, inout int err_mark);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // ########################################################################
    // link model, one step per rising edge
    // ########################################################################

    always @(posedge clk) begin : model_step
        if (rst) begin
            enc_valid  = 1'b0;
            frame_left = 0;
            model_fifo.delete();
        end else begin
            // transmitter fetches when idle or in the last cycle of a stop bit
            if (model_fifo.size() > 0 && frame_left <= 1) begin
                in_flight.push_back(model_fifo.pop_front());
                frame_left = frame_cycles;
            end else if (frame_left > 0) begin
                frame_left--;
            end
            // a full FIFO drops the write
            if (enc_valid && model_fifo.size() < fifo_depth) begin
                model_fifo.push_back(enc_byte);
            end
            enc_valid = multiplayer && (local_events != '0);
            // hit beats ready, ready beats lost
            enc_byte  = local_events.hit ? msg_hit : (local_events.ready ? msg_ready : msg_lost);
        end
    end

    always @(negedge clk) begin : watch_decoder
        logic [7:0] want;
        if (!rst && remote_events != '0) begin
            decoded++;
            if (in_flight.size() == 0) begin
                errors++;
                $display("Error: remote event pulse at cycle %0d with no message in flight", cycle);
            end else begin
                want = in_flight.pop_front();
                compare("remote_events", {5'b0, remote_events},
                        {5'b0, want == msg_lost, want == msg_ready, want == msg_hit});
                compare("last_char", last_char, want);
            end
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= cycle_limit) begin
            $display("Error: run did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ########################################################################
    // stimulus
    // ########################################################################

    initial begin : stimulus
        int mark;
        int base;
        rst          = 1'b1;
        multiplayer  = 1'b0;
        local_events = '0;
        link_up      = 1'b0;
        rng          = 32'd98;
        mark         = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst     = 1'b0;
        link_up = 1'b1;

        // idle line after reset
        repeat (40) begin
            @(negedge clk);
            compare("tx", {7'b0, tx}, 8'h01);
            compare("remote_events", {5'b0, remote_events}, 8'h00);
            compare("last_char", last_char, 8'h00);
        end
        report_test("reset", mark);

        // single-player mode keeps the line quiet
        repeat (200) begin
            rng = xorshift32(rng);
            apply_events(1'b0, rng[2:0]);
            compare("tx", {7'b0, tx}, 8'h01);
        end
        wait_drain();
        report_test("single_player", mark);

        // lost, ready, hit one at a time
        base = decoded;
        for (int k = 2; k >= 0; k--) begin
            apply_events(1'b1, 3'(1 << k));
            wait_drain();
        end
        compare("decoded_count", 8'(decoded - base), 8'd3);
        report_test("round_trip", mark);

        // every combination with more than one event
        base = decoded;
        for (int c = 3; c <= 7; c++) begin
            if (c != 4) begin
                apply_events(1'b1, 3'(c));
                wait_drain();
            end
        end
        compare("decoded_count", 8'(decoded - base), 8'd4);
        report_test("priority", mark);

        // six back to back, one frame in flight plus four queued
        base = decoded;
        repeat (6) begin
            rng = xorshift32(rng);
            apply_events(1'b1, 3'(1 << (rng % 3)));
        end
        wait_drain();
        compare("decoded_count", 8'(decoded - base), 8'd5);
        report_test("overflow", mark);

        repeat (random_msgs) begin
            rng = xorshift32(rng);
            // multiplayer flips about one time in eight
            apply_events((rng[7:5] == 3'd0) ? !multiplayer : multiplayer, rng[2:0]);
            apply_events(multiplayer, 3'b000);
            repeat (rng[13:8]) @(negedge clk);
        end
        wait_drain();
        report_test("random", mark);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d decoded",
                 tests_run, tests_failed, checks, errors, decoded);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== game_link.f ====
src/game_link_pkg.sv
src/uart_pkg.sv
src/link_msg_encoder.sv
src/link_tx_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/link_msg_decoder.sv
src/game_link.sv
sim/clock_gen.sv
sim/game_link_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then read the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -j 0 --top-module game_link_tb -f game_link.f \
    && ./obj_dir/Vgame_link_tb > sim.log 2>&1 \
    || echo "build or simulation step returned an error" >> sim.log
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log || exit 1
exit 0
